//--- clk_divider_top.f
+incdir+.
clk_div_pkg.sv
ratio_calc.sv
shadow_bank.sv
wave_gen.sv
clk_divider_top.sv
tb_clock_gen.sv
clk_divider_tb.sv

//--- clk_divider_tb.sv
//----------------------------
// testbench for the clock-multiple generator
// wave_o is sampled on the falling edge of int_osc
// input changes get 188 cycles to settle before measuring
// a zero or full high time is checked as a steady level
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

module clk_divider_tb;

    localparam int ROUND_CYCLES   = 93;
    localparam int SETTLE_CYCLES  = 2 * ROUND_CYCLES + 2;
    localparam int MEAS_LIMIT     = 2 * 5 * 1023;
    localparam int TIMEOUT_CYCLES = 6 * (SETTLE_CYCLES + MEAS_LIMIT) + 2000;
    localparam int RAND_SEED      = 32'h4dce_b287;

    logic                    int_osc;
    logic                    rst;
    logic [`CD_MASTER_W-1:0] master_period;
    logic [`CD_DUTY_W-1:0]   duty_cycle;
    logic [`CD_NUM_CH-1:0]   wave;
    int                      cycle_cnt;
    int                      tests_passed;
    int                      tests_failed;

    tb_clock_gen i_clk (
        .clk_o (int_osc),
        .rst_o (rst)
    );

    clk_divider_top i_dut (
        .int_osc         (int_osc),
        .rst             (rst),
        .master_period_i (master_period),
        .duty_cycle_i    (duty_cycle),
        .wave_o          (wave)
    );

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int ratio_of(input int k);
        case (k)
            0: return 1;
            1: return 2;
            2: return 3;
            default: return 5;
        endcase
    endfunction

    function automatic int model_period(input int m, input int k);
        return m * ratio_of(k);
    endfunction

    function automatic int model_high(input int per, input int d);
        return (per * d) / `CD_DUTY_FULL;
    endfunction

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic report_mismatch(input string what, input int got, input int expv);
        $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, expv);
    endtask

    task automatic finish_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAILED with %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    task automatic apply_inputs(input int m, input int d);
        @(posedge int_osc);
        master_period <= `CD_MASTER_W'(m);
        duty_cycle    <= `CD_DUTY_W'(d);
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(negedge int_osc);
    endtask

    // returns on the falling edge right after wave[k] rose
    task automatic wait_rise(input int k, output bit ok);
        logic prev;
        int   n;
        prev = wave[k];
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < MEAS_LIMIT) begin
            @(negedge int_osc);
            ok   = !prev && wave[k];
            prev = wave[k];
            n++;
        end
    endtask

    // one rise-to-rise interval starting just after a rise
    task automatic measure_cycle(input int k, output int per, output int hi, output bit ok);
        logic prev;
        per  = 0;
        hi   = 0;
        ok   = 1'b0;
        prev = 1'b1;
        while (!ok && per < MEAS_LIMIT) begin
            if (wave[k]) begin
                hi++;
            end
            per++;
            @(negedge int_osc);
            ok   = !prev && wave[k];
            prev = wave[k];
        end
    endtask

    task automatic measure_channel(input int k, input int exp_per, input int exp_hi,
                                   input int n_per, output int per_errs, output int hi_errs);
        int per;
        int hi;
        bit ok;
        per_errs = 0;
        hi_errs  = 0;
        if (exp_hi == 0 || exp_hi >= exp_per) begin
            // steady level over the window
            repeat (n_per * exp_per) begin
                @(negedge int_osc);
                assert (wave[k] == (exp_hi != 0)) else begin
                    report_mismatch($sformatf("ch%0d steady level", k), wave[k], exp_hi != 0);
                    hi_errs++;
                end
            end
        end else begin
            wait_rise(k, ok);
            if (!ok) begin
                $display("channel %0d never produced a rising edge", k);
                per_errs++;
            end
            for (int i = 0; i < n_per && ok; i++) begin
                measure_cycle(k, per, hi, ok);
                if (!ok) begin
                    $display("channel %0d lost its next rising edge", k);
                    per_errs++;
                end else begin
                    assert (per == exp_per) else begin
                        report_mismatch($sformatf("ch%0d period", k), per, exp_per);
                        per_errs++;
                    end
                    assert (hi == exp_hi) else begin
                        report_mismatch($sformatf("ch%0d high time", k), hi, exp_hi);
                        hi_errs++;
                    end
                end
            end
        end
    endtask

    task automatic check_all(input int m, input int d, input int n_per, inout int errs);
        int per;
        int pe;
        int he;
        for (int k = 0; k < `CD_NUM_CH; k++) begin
            per = model_period(m, k);
            measure_channel(k, per, model_high(per, d), n_per, pe, he);
            errs += pe + he;
        end
    endtask

    // ------------------------------
    // run limit
    // ------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge int_osc);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------
    // tests
    // ------------------------------
    initial begin
        int                    errs;
        int                    hi_errs;
        int                    pe;
        int                    he;
        int                    per;
        int                    n;
        int                    m;
        int                    d;
        logic [`CD_NUM_CH-1:0] mask;
        void'($urandom(RAND_SEED));
        master_period = 12;
        duty_cycle    = 128;
        tests_passed  = 0;
        tests_failed  = 0;

        // test 1 quiet through reset and the first round
        errs = 0;
        @(negedge int_osc);
        while (rst) begin
            assert (wave == '0) else begin
                report_mismatch("wave_o in reset", wave, 0);
                errs++;
            end
            @(negedge int_osc);
        end
        n = 0;
        while (wave == '0 && n < 2 * ROUND_CYCLES + 10) begin
            @(negedge int_osc);
            n++;
        end
        if (wave == '0) begin
            $display("wave_o never left 0 after reset");
            errs++;
        end else begin
            assert (n >= ROUND_CYCLES) else begin
                report_mismatch("cycles to first rise", n, ROUND_CYCLES);
                errs++;
            end
        end
        finish_test(1, "reset and first update", errs);

        // tests 2 and 3 at master 12 and duty 128
        errs    = 0;
        hi_errs = 0;
        for (int k = 0; k < `CD_NUM_CH; k++) begin
            per = model_period(12, k);
            measure_channel(k, per, model_high(per, 128), 3, pe, he);
            errs    += pe;
            hi_errs += he;
        end
        finish_test(2, "edge spacing", errs);
        finish_test(3, "high time", hi_errs);

        // test 4 full duty then zero duty
        errs = 0;
        apply_inputs(12, 255);
        settle();
        check_all(12, 255, 2, errs);
        apply_inputs(12, 0);
        settle();
        check_all(12, 0, 2, errs);
        finish_test(4, "duty 255 and 0", errs);

        // test 5 every active channel restarts on one cycle from all low
        errs = 0;
        mask = '0;
        for (int k = 0; k < `CD_NUM_CH; k++) begin
            if (model_high(model_period(9, k), 85) > 0) begin
                mask[k] = 1'b1;
            end
        end
        apply_inputs(9, 85);
        @(negedge int_osc);
        n = 1;
        while (wave == '0 && n < 2 * SETTLE_CYCLES) begin
            @(negedge int_osc);
            n++;
        end
        assert (n <= SETTLE_CYCLES) else begin
            report_mismatch("cycles to restart", n, SETTLE_CYCLES);
            errs++;
        end
        assert (wave == mask) else begin
            report_mismatch("wave_o at restart", wave, mask);
            errs++;
        end
        // spacing held across several rounds
        for (int k = 0; k < `CD_NUM_CH; k++) begin
            per = model_period(9, k);
            measure_channel(k, per, model_high(per, 85), 3 * ROUND_CYCLES / per + 2, pe, he);
            errs += pe + he;
        end
        finish_test(5, "aligned restart and steady phase", errs);

        // test 6 random settings
        errs = 0;
        repeat (8) begin
            m = 2 + ($urandom % 39);
            d = 1 + ($urandom % 254);
            apply_inputs(m, d);
            settle();
            check_all(m, d, 2, errs);
        end
        finish_test(6, "random settings", errs);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
//----------------------------
// testbench clock and reset
// int_osc period 20, rst high for 8 rising edges
//----------------------------
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // release lines up with the rising edge
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- clk_divider_top.sv
//----------------------------
// clock-multiple generator top level
// wave_o[k] runs at ratio {1,2,3,5}[k] times the master period
// input changes take effect within 188 cycles
// master_period_i must be at least 2
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

module clk_divider_top (
    input  wire logic                 int_osc,
    input  wire logic                 rst,
    input  wire clk_div_pkg::master_t master_period_i,
    input  wire clk_div_pkg::duty_t   duty_cycle_i,
    output logic [`CD_NUM_CH-1:0]     wave_o
);

    // calculator to bank
    logic                  wr_en;
    clk_div_pkg::ch_idx_t  wr_ch;
    clk_div_pkg::ch_time_t wr_period;
    clk_div_pkg::ch_time_t wr_high;
    logic                  commit;

    // bank to waveform counters
    clk_div_pkg::ch_time_t act_period [`CD_NUM_CH];
    clk_div_pkg::ch_time_t act_high [`CD_NUM_CH];
    logic                  update;

    ratio_calc i_calc (
        .int_osc         (int_osc),
        .rst             (rst),
        .master_period_i (master_period_i),
        .duty_cycle_i    (duty_cycle_i),
        .wr_en_o         (wr_en),
        .wr_ch_o         (wr_ch),
        .wr_period_o     (wr_period),
        .wr_high_o       (wr_high),
        .commit_o        (commit)
    );

    shadow_bank i_bank (
        .int_osc     (int_osc),
        .rst         (rst),
        .wr_en_i     (wr_en),
        .wr_ch_i     (wr_ch),
        .wr_period_i (wr_period),
        .wr_high_i   (wr_high),
        .commit_i    (commit),
        .period_o    (act_period),
        .high_o      (act_high),
        .update_o    (update)
    );

    wave_gen i_wave (
        .int_osc  (int_osc),
        .rst      (rst),
        .period_i (act_period),
        .high_i   (act_high),
        .update_i (update),
        .wave_o   (wave_o)
    );

endmodule

`default_nettype wire

//--- wave_gen.sv
//----------------------------
// one period counter per channel
// all counters restart together on update_i
// output is high while the count is below the high time
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

module wave_gen (
    input  wire logic                  int_osc,
    input  wire logic                  rst,
    input  wire clk_div_pkg::ch_time_t period_i [`CD_NUM_CH],
    input  wire clk_div_pkg::ch_time_t high_i [`CD_NUM_CH],
    input  wire logic                  update_i,
    output logic [`CD_NUM_CH-1:0]      wave_o
);

    for (genvar k = 0; k < `CD_NUM_CH; k++) begin : g_ch
        clk_div_pkg::ch_time_t cnt_q;
        clk_div_pkg::ch_time_t cnt_nxt;
        logic                  wave_q;

        // wrap after period - 1, restart on a new bank
        always_comb begin
            if (update_i) begin
                cnt_nxt = '0;
            end else if (cnt_q >= period_i[k] - 1'b1) begin
                cnt_nxt = '0;
            end else begin
                cnt_nxt = cnt_q + 1'b1;
            end
        end

        // compare on the next count so the level lines up with it
        always_ff @(posedge int_osc or posedge rst) begin
            if (rst) begin
                cnt_q  <= '0;
                wave_q <= 1'b0;
            end else begin
                cnt_q  <= cnt_nxt;
                wave_q <= (cnt_nxt < high_i[k]);
            end
        end

        assign wave_o[k] = wave_q;
    end

endmodule

`default_nettype wire

//--- shadow_bank.sv
//----------------------------
// staging bank written one channel at a time,
// copied to the active bank on commit only when it differs
// active bank resets to period all ones and high time 0
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

module shadow_bank (
    input  wire logic                  int_osc,
    input  wire logic                  rst,
    input  wire logic                  wr_en_i,
    input  wire clk_div_pkg::ch_idx_t  wr_ch_i,
    input  wire clk_div_pkg::ch_time_t wr_period_i,
    input  wire clk_div_pkg::ch_time_t wr_high_i,
    input  wire logic                  commit_i,
    output clk_div_pkg::ch_time_t      period_o [`CD_NUM_CH],
    output clk_div_pkg::ch_time_t      high_o [`CD_NUM_CH],
    output logic                       update_o
);

    clk_div_pkg::ch_time_t stage_period [`CD_NUM_CH];
    clk_div_pkg::ch_time_t stage_high [`CD_NUM_CH];
    logic                  bank_diff;
    logic                  swap;

    // ---------------------------
    // staging bank
    // ---------------------------
    always_ff @(posedge int_osc) begin
        if (wr_en_i) begin
            stage_period[wr_ch_i] <= wr_period_i;
            stage_high[wr_ch_i]   <= wr_high_i;
        end
    end

    // any channel differing from what is running
    always_comb begin
        bank_diff = 1'b0;
        for (int k = 0; k < `CD_NUM_CH; k++) begin
            if ((stage_period[k] != period_o[k]) || (stage_high[k] != high_o[k])) begin
                bank_diff = 1'b1;
            end
        end
    end

    assign swap = commit_i && bank_diff;

    // ---------------------------
    // active bank
    // ---------------------------
    // an unchanged round leaves the running phase alone
    always_ff @(posedge int_osc or posedge rst) begin
        if (rst) begin
            update_o <= 1'b0;
            for (int k = 0; k < `CD_NUM_CH; k++) begin
                period_o[k] <= '1;
                high_o[k]   <= '0;
            end
        end else begin
            update_o <= swap;
            if (swap) begin
                for (int k = 0; k < `CD_NUM_CH; k++) begin
                    period_o[k] <= stage_period[k];
                    high_o[k]   <= stage_high[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ratio_calc.sv
//----------------------------
// computes period and high time of each channel in turn
// one round is 4 x (load + 21 divide + write) + commit = 93 cycles
// inputs are sampled once, on the load of channel 0
// master_period_i below 2 gives no usable waveform
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

module ratio_calc (
    input  wire logic                 int_osc,
    input  wire logic                 rst,
    input  wire clk_div_pkg::master_t master_period_i,
    input  wire clk_div_pkg::duty_t   duty_cycle_i,
    output logic                      wr_en_o,
    output clk_div_pkg::ch_idx_t      wr_ch_o,
    output clk_div_pkg::ch_time_t     wr_period_o,
    output clk_div_pkg::ch_time_t     wr_high_o,
    output logic                      commit_o
);

    localparam int STEP_W = $clog2(`CD_PROD_W);
    localparam int REM_W  = `CD_DUTY_W + 1;

    // control state
    clk_div_pkg::calc_state_t state_q;
    clk_div_pkg::ch_idx_t     ch_q;
    logic [STEP_W-1:0]        step_q;

    // sampled inputs and datapath
    clk_div_pkg::master_t     master_q;
    clk_div_pkg::duty_t       duty_q;
    clk_div_pkg::master_t     master_sel;
    clk_div_pkg::duty_t       duty_sel;
    clk_div_pkg::ch_time_t    period_nxt;
    logic [`CD_PROD_W-1:0]    prod_nxt;
    clk_div_pkg::ch_time_t    period_q;
    logic [`CD_PROD_W-1:0]    quo_q;
    logic [`CD_DUTY_W-1:0]    rem_q;
    logic [REM_W-1:0]         rem_shift;
    logic [REM_W-1:0]         rem_sub;

    // ---------------------------
    // operand selection
    // ---------------------------
    // channel 0 opens the round and sees the live inputs
    always_comb begin
        if (ch_q == '0) begin
            master_sel = master_period_i;
            duty_sel   = duty_cycle_i;
        end else begin
            master_sel = master_q;
            duty_sel   = duty_q;
        end
        period_nxt = clk_div_pkg::ch_time_t'(master_sel)
                   * clk_div_pkg::ch_time_t'(clk_div_pkg::CH_RATIO[ch_q]);
        prod_nxt   = `CD_PROD_W'(period_nxt) * `CD_PROD_W'(duty_sel);
    end

    // one restoring step, next dividend bit shifted into the remainder
    assign rem_shift = {rem_q, quo_q[`CD_PROD_W-1]};
    assign rem_sub   = rem_shift - REM_W'(`CD_DUTY_FULL);

    // ---------------------------
    // datapath
    // ---------------------------
    always_ff @(posedge int_osc) begin
        case (state_q)
            clk_div_pkg::CALC_LOAD: begin
                if (ch_q == '0) begin
                    master_q <= master_period_i;
                    duty_q   <= duty_cycle_i;
                end
                period_q <= period_nxt;
                quo_q    <= prod_nxt;
                rem_q    <= '0;
            end
            clk_div_pkg::CALC_DIVIDE: begin
                if (rem_shift >= REM_W'(`CD_DUTY_FULL)) begin
                    rem_q <= rem_sub[`CD_DUTY_W-1:0];
                    quo_q <= {quo_q[`CD_PROD_W-2:0], 1'b1};
                end else begin
                    rem_q <= rem_shift[`CD_DUTY_W-1:0];
                    quo_q <= {quo_q[`CD_PROD_W-2:0], 1'b0};
                end
            end
            default: begin
            end
        endcase
    end

    // ---------------------------
    // sequencing FSM
    // ---------------------------
    always_ff @(posedge int_osc or posedge rst) begin
        if (rst) begin
            state_q <= clk_div_pkg::CALC_LOAD;
            ch_q    <= '0;
            step_q  <= '0;
        end else begin
            case (state_q)
                clk_div_pkg::CALC_LOAD: begin
                    step_q  <= '0;
                    state_q <= clk_div_pkg::CALC_DIVIDE;
                end
                clk_div_pkg::CALC_DIVIDE: begin
                    // one quotient bit per cycle, 21 cycles
                    if (step_q == STEP_W'(`CD_PROD_W - 1)) begin
                        state_q <= clk_div_pkg::CALC_WRITE;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                clk_div_pkg::CALC_WRITE: begin
                    if (ch_q == clk_div_pkg::ch_idx_t'(`CD_NUM_CH - 1)) begin
                        state_q <= clk_div_pkg::CALC_COMMIT;
                    end else begin
                        ch_q    <= ch_q + 1'b1;
                        state_q <= clk_div_pkg::CALC_LOAD;
                    end
                end
                default: begin
                    ch_q    <= '0;
                    state_q <= clk_div_pkg::CALC_LOAD;
                end
            endcase
        end
    end

    // quotient never exceeds the period, so its low bits hold it
    assign wr_en_o     = (state_q == clk_div_pkg::CALC_WRITE);
    assign wr_ch_o     = ch_q;
    assign wr_period_o = period_q;
    assign wr_high_o   = quo_q[`CD_CH_W-1:0];
    assign commit_o    = (state_q == clk_div_pkg::CALC_COMMIT);

endmodule

`default_nettype wire

//--- clk_div_pkg.sv
//----------------------------
// shared types for the clock-multiple generator
// ratio table order sets the bit order of wave_o
//----------------------------
`default_nettype none

`include "clk_div_params.svh"

package clk_div_pkg;

    // value types
    typedef logic [`CD_MASTER_W-1:0] master_t;
    typedef logic [`CD_DUTY_W-1:0]   duty_t;
    typedef logic [`CD_CH_W-1:0]     ch_time_t;
    typedef logic [1:0]              ch_idx_t;
    typedef logic [2:0]              ratio_t;

    // period multiple of each channel
    localparam ratio_t CH_RATIO [`CD_NUM_CH] = '{3'd1, 3'd2, 3'd3, 3'd5};

    // calculator FSM
    typedef enum logic [1:0] {
        CALC_LOAD,
        CALC_DIVIDE,
        CALC_WRITE,
        CALC_COMMIT
    } calc_state_t;

endpackage

`default_nettype wire

//--- clk_div_params.svh
//----------------------------
// width and count macros for the clock-multiple generator
// CD_CH_W must hold the largest master period times 5
// CD_PROD_W must hold a channel period times full duty,
// it also sets the number of divider steps per channel
//----------------------------
`ifndef CLK_DIV_PARAMS_SVH
`define CLK_DIV_PARAMS_SVH

// master period input, in int_osc cycles
`define CD_MASTER_W 10

// duty input and its full-scale value (100 % high)
`define CD_DUTY_W 8
`define CD_DUTY_FULL 255

// output channels
`define CD_NUM_CH 4

// channel period and high time, 1023 * 5 fits in 13 bits
`define CD_CH_W 13

// period * duty product, 13 + 8 bits
`define CD_PROD_W 21

`endif
